// ==== common/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_slt     = 3'b010;
    // word width for lw and sw
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_type_t;

    // four ways to read one fetched word
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
    } inst_word_u;

endpackage

// ==== execute/alu.sv ====
`timescale 1ns/1ns

module alu
    import rv_pkg::*;
(
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] y
);

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_and:    y = a & b;
            alu_or:     y = a | b;
            alu_xor:    y = a ^ b;
            alu_slt:    y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            // lui
            alu_pass_b: y = b;
            default:    y = '0;
        endcase
    end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ns

module reg_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] wr_rd,
    input  logic                  wr_en,
    input  logic [xlen-1:0]       wr_data,
    output logic [xlen-1:0]       rs1_val,
    output logic [xlen-1:0]       rs2_val
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_rd != '0)
            regs[wr_rd] <= wr_data;
    end

    // same-cycle write shows through
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wr_en && wr_rd == rs1) ? wr_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wr_en && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic [xlen-1:0] imem_rdata,
    output logic [xlen-1:0] imem_addr,
    output logic            fd_valid,
    output inst_word_u      fd_inst,
    output logic [xlen-1:0] fd_pc
);

    logic [xlen-1:0] pc;

    assign imem_addr = pc;

    // redirect beats stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            fd_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_inst <= imem_rdata;
            fd_pc   <= pc;
        end
    end

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fd_valid,
    input  inst_word_u            fd_inst,
    input  logic [xlen-1:0]       fd_pc,
    input  logic                  redirect,
    input  logic                  ex_valid,
    input  logic                  ex_is_load,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_result,
    input  logic                  mem_fwd_valid,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic [xlen-1:0]       mem_fwd_data,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  stall,
    output logic                  de_valid,
    output alu_op_t               de_op,
    output logic [xlen-1:0]       de_a,
    output logic [xlen-1:0]       de_b,
    output logic [xlen-1:0]       de_rs2_val,
    output logic [xlen-1:0]       de_imm,
    output logic [xlen-1:0]       de_pc,
    output logic [reg_addr_w-1:0] de_rd,
    output logic                  de_is_load,
    output logic                  de_is_store,
    output logic                  de_is_branch,
    output logic                  de_branch_ne,
    output logic                  de_use_imm,
    output logic                  de_writes_rd
);

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rf_rs1;
    logic [xlen-1:0]       rf_rs2;
    logic [xlen-1:0]       a_fwd;
    logic [xlen-1:0]       b_fwd;
    alu_op_t               op;
    logic [xlen-1:0]       imm;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  use_imm;
    logic                  writes_rd;

    assign rs1 = fd_inst.r.rs1;
    assign rs2 = fd_inst.r.rs2;

    // write-back source comes in through the register file bypass
    reg_file u_reg_file (
        .clk    (clk),
        .rs1    (rs1),
        .rs2    (rs2),
        .wr_rd  (wb_rd),
        .wr_en  (wb_valid),
        .wr_data(wb_data),
        .rs1_val(rf_rs1),
        .rs2_val(rf_rs2)
    );

    always_comb begin
        if (ex_valid && ex_rd != '0 && ex_rd == rs1)
            a_fwd = ex_result;
        else if (mem_fwd_valid && mem_rd == rs1)
            a_fwd = mem_fwd_data;
        else
            a_fwd = rf_rs1;

        if (ex_valid && ex_rd != '0 && ex_rd == rs2)
            b_fwd = ex_result;
        else if (mem_fwd_valid && mem_rd == rs2)
            b_fwd = mem_fwd_data;
        else
            b_fwd = rf_rs2;
    end

    // load result not ready until it reaches memory stage
    assign stall = fd_valid && ex_valid && ex_is_load && ex_rd != '0 &&
                   (ex_rd == rs1 || ex_rd == rs2);

    always_comb begin
        op        = alu_add;
        imm       = {{20{fd_inst.i.imm12[11]}}, fd_inst.i.imm12};
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        case (fd_inst.r.opcode)
            opc_op: begin
                writes_rd = 1'b1;
                case (fd_inst.r.funct3)
                    f3_add_sub: op = (fd_inst.r.funct7 == funct7_sub) ? alu_sub : alu_add;
                    f3_xor:     op = alu_xor;
                    f3_or:      op = alu_or;
                    f3_and:     op = alu_and;
                    f3_slt:     op = alu_slt;
                    default:    writes_rd = 1'b0;
                endcase
            end
            opc_op_imm: begin
                // addi only
                use_imm   = 1'b1;
                writes_rd = (fd_inst.i.funct3 == f3_add_sub);
            end
            opc_lui: begin
                op        = alu_pass_b;
                imm       = {fd_inst.i.imm12, fd_inst.i.rs1, fd_inst.i.funct3, 12'h000};
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            opc_load: begin
                use_imm   = 1'b1;
                is_load   = (fd_inst.i.funct3 == f3_word);
                writes_rd = (fd_inst.i.funct3 == f3_word);
            end
            opc_store: begin
                imm      = {{20{fd_inst.s.imm_hi[6]}}, fd_inst.s.imm_hi, fd_inst.s.imm_lo};
                use_imm  = 1'b1;
                is_store = (fd_inst.s.funct3 == f3_word);
            end
            opc_branch: begin
                imm       = {{20{fd_inst.b.imm12}}, fd_inst.b.imm11, fd_inst.b.imm10_5,
                             fd_inst.b.imm4_1, 1'b0};
                is_branch = (fd_inst.b.funct3 == f3_beq || fd_inst.b.funct3 == f3_bne);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            de_valid <= 1'b0;
        else
            de_valid <= fd_valid && !stall && !redirect;
    end

    always_ff @(posedge clk) begin
        de_op        <= op;
        de_a         <= a_fwd;
        de_b         <= b_fwd;
        de_rs2_val   <= b_fwd;
        de_imm       <= imm;
        de_pc        <= fd_pc;
        // rd zero marks a non-writer for the hazard compares
        de_rd        <= writes_rd ? fd_inst.r.rd : '0;
        de_is_load   <= is_load;
        de_is_store  <= is_store;
        de_is_branch <= is_branch;
        de_branch_ne <= (fd_inst.b.funct3 == f3_bne);
        de_use_imm   <= use_imm;
        de_writes_rd <= writes_rd;
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  de_valid,
    input  alu_op_t               de_op,
    input  logic [xlen-1:0]       de_a,
    input  logic [xlen-1:0]       de_b,
    input  logic [xlen-1:0]       de_rs2_val,
    input  logic [xlen-1:0]       de_imm,
    input  logic [xlen-1:0]       de_pc,
    input  logic [reg_addr_w-1:0] de_rd,
    input  logic                  de_is_load,
    input  logic                  de_is_store,
    input  logic                  de_is_branch,
    input  logic                  de_branch_ne,
    input  logic                  de_use_imm,
    input  logic                  de_writes_rd,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  ex_valid,
    output logic                  ex_is_load,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic                  em_valid,
    output logic [xlen-1:0]       em_result,
    output logic [xlen-1:0]       em_store_data,
    output logic [reg_addr_w-1:0] em_rd,
    output logic                  em_is_load,
    output logic                  em_is_store,
    output logic                  em_writes_rd
);

    logic [xlen-1:0] alu_b;
    logic            taken;

    assign alu_b = de_use_imm ? de_imm : de_b;

    alu u_alu (
        .op(de_op),
        .a (de_a),
        .b (alu_b),
        .y (ex_result)
    );

    // beq on equal, bne on not equal
    assign taken       = (de_a == de_b) ^ de_branch_ne;
    assign redirect    = de_valid && de_is_branch && taken;
    assign redirect_pc = de_pc + de_imm;

    assign ex_valid   = de_valid;
    assign ex_is_load = de_is_load;
    assign ex_rd      = de_rd;

    always_ff @(posedge clk) begin
        if (!rst_n)
            em_valid <= 1'b0;
        else
            em_valid <= de_valid;
    end

    always_ff @(posedge clk) begin
        em_result     <= ex_result;
        em_store_data <= de_rs2_val;
        em_rd         <= de_rd;
        em_is_load    <= de_is_load;
        em_is_store   <= de_is_store;
        em_writes_rd  <= de_writes_rd;
    end

endmodule

// ==== hw/mem_wb_stage.sv ====
`timescale 1ns/1ns

module mem_wb_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  em_valid,
    input  logic [xlen-1:0]       em_result,
    input  logic [xlen-1:0]       em_store_data,
    input  logic [reg_addr_w-1:0] em_rd,
    input  logic                  em_is_load,
    input  logic                  em_is_store,
    input  logic                  em_writes_rd,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    output logic                  dmem_we,
    output logic                  mem_fwd_valid,
    output logic [xlen-1:0]       mem_fwd_data,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    assign dmem_addr  = em_result;
    assign dmem_wdata = em_store_data;
    assign dmem_we    = em_valid && em_is_store;

    // memory-stage value is also a forwarding source for decode
    assign mem_fwd_valid = em_valid && em_writes_rd && em_rd != '0;
    assign mem_fwd_data  = em_is_load ? dmem_rdata : em_result;

    always_ff @(posedge clk) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_fwd_valid;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= em_rd;
        wb_data <= mem_fwd_data;
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns

module rv_core
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [xlen-1:0]       imem_addr,
    input  logic [xlen-1:0]       imem_rdata,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    output logic                  dmem_we,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_data
);

    logic                  stall;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;
    logic                  fd_valid;
    inst_word_u            fd_inst;
    logic [xlen-1:0]       fd_pc;
    logic                  de_valid;
    alu_op_t               de_op;
    logic [xlen-1:0]       de_a;
    logic [xlen-1:0]       de_b;
    logic [xlen-1:0]       de_rs2_val;
    logic [xlen-1:0]       de_imm;
    logic [xlen-1:0]       de_pc;
    logic [reg_addr_w-1:0] de_rd;
    logic                  de_is_load;
    logic                  de_is_store;
    logic                  de_is_branch;
    logic                  de_branch_ne;
    logic                  de_use_imm;
    logic                  de_writes_rd;
    logic                  ex_valid;
    logic                  ex_is_load;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic                  em_valid;
    logic [xlen-1:0]       em_result;
    logic [xlen-1:0]       em_store_data;
    logic [reg_addr_w-1:0] em_rd;
    logic                  em_is_load;
    logic                  em_is_store;
    logic                  em_writes_rd;
    logic                  mem_fwd_valid;
    logic [xlen-1:0]       mem_fwd_data;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .fd_valid   (fd_valid),
        .fd_inst    (fd_inst),
        .fd_pc      (fd_pc)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fd_valid     (fd_valid),
        .fd_inst      (fd_inst),
        .fd_pc        (fd_pc),
        .redirect     (redirect),
        .ex_valid     (ex_valid),
        .ex_is_load   (ex_is_load),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .mem_fwd_valid(mem_fwd_valid),
        .mem_rd       (em_rd),
        .mem_fwd_data (mem_fwd_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .de_valid     (de_valid),
        .de_op        (de_op),
        .de_a         (de_a),
        .de_b         (de_b),
        .de_rs2_val   (de_rs2_val),
        .de_imm       (de_imm),
        .de_pc        (de_pc),
        .de_rd        (de_rd),
        .de_is_load   (de_is_load),
        .de_is_store  (de_is_store),
        .de_is_branch (de_is_branch),
        .de_branch_ne (de_branch_ne),
        .de_use_imm   (de_use_imm),
        .de_writes_rd (de_writes_rd)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .de_valid     (de_valid),
        .de_op        (de_op),
        .de_a         (de_a),
        .de_b         (de_b),
        .de_rs2_val   (de_rs2_val),
        .de_imm       (de_imm),
        .de_pc        (de_pc),
        .de_rd        (de_rd),
        .de_is_load   (de_is_load),
        .de_is_store  (de_is_store),
        .de_is_branch (de_is_branch),
        .de_branch_ne (de_branch_ne),
        .de_use_imm   (de_use_imm),
        .de_writes_rd (de_writes_rd),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .ex_valid     (ex_valid),
        .ex_is_load   (ex_is_load),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .em_valid     (em_valid),
        .em_result    (em_result),
        .em_store_data(em_store_data),
        .em_rd        (em_rd),
        .em_is_load   (em_is_load),
        .em_is_store  (em_is_store),
        .em_writes_rd (em_writes_rd)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .em_valid     (em_valid),
        .em_result    (em_result),
        .em_store_data(em_store_data),
        .em_rd        (em_rd),
        .em_is_load   (em_is_load),
        .em_is_store  (em_is_store),
        .em_writes_rd (em_writes_rd),
        .dmem_rdata   (dmem_rdata),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .mem_fwd_valid(mem_fwd_valid),
        .mem_fwd_data (mem_fwd_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

    localparam int test_count      = 6;
    localparam int cycles_per_test = 200;
    // reset, loading and the retire wait of one test fit in one slot
    localparam int max_cycles      = test_count * cycles_per_test;
    localparam int wait_limit      = 180;

    // {funct7, funct3} of the register-register operations
    localparam logic [9:0] fn_add = {7'h00, 3'h0};
    localparam logic [9:0] fn_sub = {7'h20, 3'h0};
    localparam logic [9:0] fn_and = {7'h00, 3'h7};
    localparam logic [9:0] fn_or  = {7'h00, 3'h6};
    localparam logic [9:0] fn_xor = {7'h00, 3'h4};
    localparam logic [9:0] fn_slt = {7'h00, 3'h2};

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];

    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_mem_addr [$];
    logic [31:0] exp_mem_data [$];

    int     errors;
    int     checks;
    int     cycle_count;
    int     first_retire_cycle;
    int     first_store_cycle;
    integer seed;

    rv_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .dmem_rdata  (dmem_rdata),
        .retire_valid(retire_valid),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    always #5 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run reached %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_word(input logic [9:0] fn, input logic [4:0] rd, rs1, rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'h33};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'h0, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'h2, rd, 7'h03};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], 7'h23};
    endfunction

    // off is the byte offset from the branch itself
    function automatic logic [31:0] branch_word(input logic [2:0] f3,
                                                input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'h37};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h9e37_79b9 * (idx + 1);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_retire(input logic [4:0] rd, input logic [31:0] data);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] data);
        exp_mem_addr.push_back(addr);
        exp_mem_data.push_back(data);
    endtask

    task automatic clear_test;
        int i;
        for (i = 0; i < 256; i++) begin
            // addi x0 filler never retires
            imem[i] = addi_word(5'd0, 5'd0, i[11:0]);
            dmem[i] = fill_word(i);
        end
        prog.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_mem_addr.delete();
        exp_mem_data.delete();
    endtask

    task automatic apply_reset;
        int i;
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3)
                #1 rst_n = 1'b1;
            @(negedge clk);
            checks += 3;
            if (retire_valid !== 1'b0) begin
                errors++;
                $display("mismatch retire_valid in reset: got %h, expected 0", retire_valid);
            end
            if (dmem_we !== 1'b0) begin
                errors++;
                $display("mismatch dmem_we in reset: got %h, expected 0", dmem_we);
            end
            if (imem_addr !== 32'h0) begin
                errors++;
                $display("mismatch imem_addr in reset: got %h, expected 00000000", imem_addr);
            end
        end
    endtask

    // cycle k = 1 is the cycle after the first fetch
    task automatic collect_retirements;
        int got;
        int k;
        got = 0;
        k = 0;
        first_retire_cycle = 0;
        first_store_cycle = 0;
        while (got < exp_rd.size() && k < wait_limit) begin
            @(negedge clk);
            k++;
            if (dmem_we === 1'b1 && first_store_cycle == 0)
                first_store_cycle = k;
            if (retire_valid === 1'b1) begin
                if (first_retire_cycle == 0)
                    first_retire_cycle = k;
                checks += 2;
                if (retire_rd == 5'd0) begin
                    errors++;
                    $display("retirement %0d reported a write to x0", got);
                end else if (retire_rd !== exp_rd[got]) begin
                    errors++;
                    $display("mismatch retire_rd at retirement %0d: got %h, expected %h",
                             got, retire_rd, exp_rd[got]);
                end
                if (retire_data !== exp_data[got]) begin
                    errors++;
                    $display("mismatch retire_data at retirement %0d: got %h, expected %h",
                             got, retire_data, exp_data[got]);
                end
                got++;
            end
        end
        if (got < exp_rd.size()) begin
            errors++;
            $display("only %0d of %0d expected retirements arrived", got, exp_rd.size());
        end
    endtask

    task automatic compare_memory;
        int i;
        logic [31:0] a;
        for (i = 0; i < exp_mem_addr.size(); i++) begin
            a = exp_mem_addr[i];
            checks++;
            if (dmem[a[9:2]] !== exp_mem_data[i]) begin
                errors++;
                $display("mismatch dmem[%h]: got %h, expected %h", a, dmem[a[9:2]],
                         exp_mem_data[i]);
            end
        end
    endtask

    task automatic run_program(input string name);
        int i;
        $display("running %s", name);
        for (i = 0; i < prog.size(); i++)
            imem[i] = prog[i];
        // endless beq x0, x0, 0 parks the core
        imem[prog.size()] = branch_word(3'h0, 5'd0, 5'd0, 13'd0);
        apply_reset();
        collect_retirements();
        compare_memory();
    endtask

    task automatic alu_chain;
        logic [31:0] v1, v2, v3, v4, v5, v6, v7, v8, v9, v10;
        clear_test();
        v1 = 32'h0000_0005;
        v2 = 32'h0000_0002;
        v3 = 32'h0000_0007;
        v4 = 32'h0000_0002;
        v5 = 32'h0000_0002;
        v6 = 32'h0000_0007;
        v7 = 32'h0000_0005;
        v8 = 32'h0000_0001;
        // minus five
        v9 = 32'hffff_fffb;
        v10 = 32'h0000_0001;
        emit(addi_word(1, 0, 5));
        expect_retire(1, v1);
        emit(addi_word(2, 1, -3));
        expect_retire(2, v2);
        emit(r_word(fn_add, 3, 1, 2));
        expect_retire(3, v3);
        emit(r_word(fn_sub, 4, 3, 1));
        expect_retire(4, v4);
        emit(r_word(fn_and, 5, 4, 3));
        expect_retire(5, v5);
        emit(r_word(fn_or, 6, 5, 1));
        expect_retire(6, v6);
        emit(r_word(fn_xor, 7, 6, 2));
        expect_retire(7, v7);
        emit(r_word(fn_slt, 8, 4, 7));
        expect_retire(8, v8);
        emit(r_word(fn_sub, 9, 0, 7));
        expect_retire(9, v9);
        emit(r_word(fn_slt, 10, 9, 8));
        expect_retire(10, v10);
        emit(lui_word(11, 20'h12345));
        expect_retire(11, 32'h1234_5000);
        emit(r_word(fn_add, 12, 11, 10));
        expect_retire(12, 32'h1234_5001);
        run_program("alu chain");
    endtask

    task automatic load_use;
        logic [31:0] w0, w1;
        clear_test();
        w0 = 32'h0000_1234;
        w1 = 32'hffff_ff00;
        dmem[4] = w0;
        dmem[5] = w1;
        emit(addi_word(1, 0, 16));
        expect_retire(1, 32'd16);
        emit(lw_word(2, 1, 0));
        expect_retire(2, w0);
        emit(r_word(fn_add, 3, 2, 2));
        expect_retire(3, 32'h0000_2468);
        emit(lw_word(4, 1, 4));
        expect_retire(4, w1);
        emit(addi_word(5, 4, 1));
        expect_retire(5, 32'hffff_ff01);
        emit(lw_word(6, 1, 4));
        expect_retire(6, w1);
        emit(r_word(fn_sub, 7, 3, 6));
        expect_retire(7, 32'h0000_2568);
        run_program("load-use");
    endtask

    task automatic store_reload;
        clear_test();
        emit(addi_word(1, 0, 64));
        expect_retire(1, 32'd64);
        emit(addi_word(2, 0, 12'h123));
        expect_retire(2, 32'h123);
        emit(r_word(fn_add, 3, 2, 2));
        expect_retire(3, 32'h246);
        emit(sw_word(3, 1, 0));
        emit(sw_word(2, 1, 8));
        emit(addi_word(4, 1, 4));
        expect_retire(4, 32'd68);
        emit(sw_word(4, 4, 0));
        emit(lw_word(7, 4, 0));
        expect_retire(7, 32'd68);
        emit(lw_word(5, 1, 0));
        expect_retire(5, 32'h246);
        emit(lw_word(6, 1, 8));
        expect_retire(6, 32'h123);
        expect_word(32'd64, 32'h246);
        expect_word(32'd68, 32'd68);
        expect_word(32'd72, 32'h123);
        // neighbour word keeps its fill
        expect_word(32'd76, fill_word(19));
        run_program("store and reload");
    endtask

    task automatic branch_flush;
        logic [11:0] shadow_imm [0:5];
        logic [31:0] c_val;
        logic [31:0] f_val;
        int i;
        clear_test();
        for (i = 0; i < 6; i++)
            shadow_imm[i] = $random(seed);
        c_val = {{20{shadow_imm[2][11]}}, shadow_imm[2]};
        f_val = {{20{shadow_imm[5][11]}}, shadow_imm[5]};
        emit(addi_word(1, 0, 7));
        expect_retire(1, 32'd7);
        emit(addi_word(2, 0, 7));
        expect_retire(2, 32'd7);
        // beq taken over two shadow instructions
        emit(branch_word(3'h0, 1, 2, 12));
        emit(addi_word(3, 0, shadow_imm[0]));
        emit(addi_word(4, 0, shadow_imm[1]));
        emit(branch_word(3'h1, 1, 2, 8));
        emit(addi_word(5, 0, shadow_imm[2]));
        expect_retire(5, c_val);
        emit(addi_word(6, 1, 1));
        expect_retire(6, 32'd8);
        // bne taken
        emit(branch_word(3'h1, 6, 1, 12));
        emit(addi_word(7, 0, shadow_imm[3]));
        emit(addi_word(8, 0, shadow_imm[4]));
        emit(branch_word(3'h0, 6, 1, 8));
        emit(addi_word(9, 6, shadow_imm[5]));
        expect_retire(9, 32'd8 + f_val);
        run_program("branches");
    endtask

    task automatic zero_register;
        clear_test();
        emit(addi_word(0, 0, 55));
        emit(addi_word(1, 0, 9));
        expect_retire(1, 32'd9);
        emit(r_word(fn_add, 0, 1, 1));
        emit(r_word(fn_add, 2, 0, 1));
        expect_retire(2, 32'd9);
        emit(lui_word(0, 20'habcde));
        emit(r_word(fn_sub, 3, 1, 0));
        expect_retire(3, 32'd9);
        emit(lw_word(0, 0, 0));
        emit(r_word(fn_or, 4, 0, 0));
        expect_retire(4, 32'd0);
        emit(addi_word(5, 0, -1));
        expect_retire(5, 32'hffff_ffff);
        run_program("x0 handling");
    endtask

    task automatic reset_timing;
        clear_test();
        emit(addi_word(1, 0, 12'h05a));
        expect_retire(1, 32'h5a);
        emit(sw_word(1, 0, 32));
        emit(addi_word(2, 1, 1));
        expect_retire(2, 32'h5b);
        expect_word(32'd32, 32'h5a);
        run_program("reset and first retirement");
        checks += 2;
        if (first_retire_cycle != 4) begin
            errors++;
            $display("first retirement came %0d cycles after the first fetch, not 4",
                     first_retire_cycle);
        end
        // store fetched one cycle later reaches memory in the same cycle
        if (first_store_cycle != 4) begin
            errors++;
            $display("first store came %0d cycles after the first fetch, not 4",
                     first_store_cycle);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        errors = 0;
        checks = 0;
        cycle_count = 0;
        first_retire_cycle = 0;
        first_store_cycle = 0;
        seed = 42;
        clear_test();
        alu_chain();
        load_use();
        store_reload();
        branch_flush();
        zero_register();
        reset_timing();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== compile.f ====
common/rv_pkg.sv
execute/alu.sv
decode/reg_file.sv
hw/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
hw/mem_wb_stage.sv
hw/rv_core.sv
verif/tb_rv_core.sv
